// ==== design/busPkg.sv ====
// CPU bus types shared by the glue RTL and its testbench; import where bus signals are handled
package busPkg;

    // Byte address as driven by the 68010 (A23..A0, A0 implied by the data strobes)
    typedef logic [23:0] cpuAddr_t;

    // Function code pins FC2..FC0
    typedef logic [2:0] funcCode_t;

    // Interrupt priority level, zero when nothing is pending
    typedef logic [2:0] intLevel_t;

    // Function code of an interrupt acknowledge (CPU space) cycle
    localparam funcCode_t FC_INT_ACK = 3'b111;

    // One sampled bus state, 31 bits
    typedef struct packed {
        cpuAddr_t  addr;
        logic      readNotWrite; // High for a read
        logic      upperN;       // UDS, active low
        logic      lowerN;       // LDS, active low
        funcCode_t fc;
        logic      active;       // AS asserted
    } busCycle_t;

endpackage

// ==== design/mapPkg.sv ====
// Memory map of the video board and the decoded select bundle; used by the decoder and strobe logic
package mapPkg;

    // Memory map
    //   A23..A22 = 00  ROM, bank by A17..A16, reads only
    //   A23..A22 = 01  Work RAM, A12 low ram0, A12 high ram1
    //   A23..A22 = 10  Video bus, split by A21..A20
    //       00  control registers by A19..A17, lower byte writes only
    //       01  unmapped
    //       10  VRAM, slow
    //       11  CRAM, slow
    //   A23..A22 = 11  I/O by A19..A17, slow

    typedef logic [1:0] region_t;

    localparam region_t REGION_ROM   = 2'b00;
    localparam region_t REGION_RAM   = 2'b01;
    localparam region_t REGION_VIDEO = 2'b10;
    localparam region_t REGION_IO    = 2'b11;

    // Video bus sub regions from A21..A20
    localparam region_t VID_REGS = 2'b00;
    localparam region_t VID_NONE = 2'b01;
    localparam region_t VID_VRAM = 2'b10;
    localparam region_t VID_CRAM = 2'b11;

    typedef logic [3:0] romBank_t; // One-hot active low

    // Bit 0 hscroll, 1 vscroll, 2 playfield special, 3 misc,
    // 4 watchdog, 5 vblank ack, 6 unlock, 7 unused
    typedef logic [7:0] regSel_t;

    // Bit 0 input port, 1 sound read, 2 sound write, 3 EEPROM, 4..7 spare
    typedef logic [7:0] ioSel_t;

    typedef struct packed {
        romBank_t rom;
        logic     ram0N;
        logic     ram1N;
        logic     vramN;
        logic     cramN;
        regSel_t  regs;
        ioSel_t   io;
        logic     slow;  // Region needs wait states
        logic     valid; // A cycle is being decoded
    } mapSel_t;

    // Nothing selected, no cycle
    localparam mapSel_t SEL_IDLE = '{
        rom:   4'hF,
        ram0N: 1'b1,
        ram1N: 1'b1,
        vramN: 1'b1,
        cramN: 1'b1,
        regs:  8'hFF,
        io:    8'hFF,
        slow:  1'b0,
        valid: 1'b0
    };

endpackage

// ==== design/busSampler.sv ====
// Input stage of the bus glue; registers the CPU bus on VRAC2 and encodes the interrupt lines
module busSampler (
    input  logic               VRAC2,
    input  logic               rst,
    input  busPkg::cpuAddr_t   addr,
    input  logic               rdWrN,
    input  logic               asN,
    input  logic               udsN,
    input  logic               ldsN,
    input  busPkg::funcCode_t  fc,
    input  logic               soundIntN,
    input  logic               vblankIntN,
    input  logic               int3N,
    input  logic               joystickIntN,
    input  logic               int1N,
    output busPkg::busCycle_t  cycle,
    output busPkg::intLevel_t  iplN
);

    import busPkg::*;

    intLevel_t pendLevel;

    // Priority encoder, later lines override earlier ones
    always_comb begin
        pendLevel = 3'd0;
        if (!int1N) begin
            pendLevel = 3'd1;
        end
        if (!joystickIntN) begin
            pendLevel = 3'd2;
        end
        if (!int3N) begin
            pendLevel = 3'd3;
        end
        if (!vblankIntN) begin
            pendLevel = 3'd4;
        end
        if (!soundIntN) begin
            pendLevel = 3'd6; // Sound wins over everything
        end
    end

    always_ff @(posedge VRAC2) begin
        if (rst) begin
            cycle.active <= 1'b0;
            iplN         <= 3'b111;
        end else begin
            cycle.addr         <= addr;
            cycle.readNotWrite <= rdWrN;
            cycle.upperN       <= udsN;
            cycle.lowerN       <= ldsN;
            cycle.fc           <= fc;
            cycle.active       <= ~asN; // Strobe becomes an active flag
            iplN               <= ~pendLevel; // IPL pins are inverted
        end
    end

endmodule

// ==== design/addressDecoder.sv ====
// Memory map decoder; turns a sampled bus cycle into registered active-low chip selects
module addressDecoder (
    input  logic              VRAC2,
    input  logic              rst,
    input  busPkg::busCycle_t cycle,
    output mapPkg::mapSel_t   sel,
    output busPkg::busCycle_t cycleDly
);

    import busPkg::*;
    import mapPkg::*;

    mapSel_t nextSel;
    logic    intAck;
    logic    lowerWrite;

    assign intAck     = (cycle.fc == FC_INT_ACK);
    assign lowerWrite = ~cycle.readNotWrite & ~cycle.lowerN;

    always_comb begin
        nextSel       = SEL_IDLE;
        nextSel.valid = cycle.active;

        // CPU space cycles touch no memory
        if (cycle.active && !intAck) begin
            case (region_t'(cycle.addr[23:22]))
                REGION_ROM: begin
                    if (cycle.readNotWrite) begin
                        nextSel.rom[cycle.addr[17:16]] = 1'b0;
                    end
                end
                REGION_RAM: begin
                    nextSel.ram0N = cycle.addr[12];  // A12 low
                    nextSel.ram1N = ~cycle.addr[12]; // A12 high
                end
                REGION_VIDEO: begin
                    case (region_t'(cycle.addr[21:20]))
                        VID_REGS: begin
                            // Registers are write only, lower byte lane
                            if (lowerWrite && cycle.addr[19:17] != 3'd7) begin
                                nextSel.regs[cycle.addr[19:17]] = 1'b0;
                            end
                        end
                        VID_NONE: begin
                            // Unmapped, acked fast with nothing selected
                        end
                        VID_VRAM: begin
                            nextSel.vramN = 1'b0;
                            nextSel.slow  = 1'b1;
                        end
                        VID_CRAM: begin
                            nextSel.cramN = 1'b0;
                            nextSel.slow  = 1'b1;
                        end
                    endcase
                end
                REGION_IO: begin
                    // Only the low four device codes exist
                    if (!cycle.addr[19]) begin
                        nextSel.io[cycle.addr[19:17]] = 1'b0;
                    end
                    nextSel.slow = 1'b1;
                end
            endcase
        end
    end

    // Selects and the cycle that produced them stay aligned
    always_ff @(posedge VRAC2) begin
        if (rst) begin
            sel             <= SEL_IDLE;
            cycleDly.active <= 1'b0;
        end else begin
            sel      <= nextSel;
            cycleDly <= cycle;
        end
    end

endmodule

// ==== design/strobeGen.sv ====
// Output stage of the bus glue; qualifies selects with the byte strobes and answers DTACK or VPA
module strobeGen #(
    parameter int WAIT_STATES = 2
) (
    input  logic              VRAC2,
    input  logic              rst,
    input  mapPkg::mapSel_t   sel,
    input  busPkg::busCycle_t cycleDly,
    input  logic              waitN,
    output mapPkg::romBank_t  romN,
    output logic              ram0N,
    output logic              ram1N,
    output logic              vramRdN,
    output logic              vramWrN,
    output logic              cramWrN,
    output mapPkg::regSel_t   regN,
    output mapPkg::ioSel_t    ioN,
    output logic              writeHighN,
    output logic              writeLowN,
    output logic              readLowN,
    output logic              dtackN,
    output logic              vpaN
);

    import busPkg::*;

    // Wide enough to hold WAIT_STATES itself
    localparam int CNT_W = $clog2(WAIT_STATES + 2);
    localparam logic [CNT_W-1:0] WAIT_CNT = CNT_W'(WAIT_STATES);

    typedef enum logic [1:0] {
        stIdle,
        stWaiting,
        stAcked
    } ackState_t;

    ackState_t        state;
    logic [CNT_W-1:0] waitCnt;
    logic             waitQ;
    logic             intAck;
    logic             waitDone;

    // Byte lane strobes, only inside a sampled cycle
    assign writeHighN = ~(cycleDly.active & ~cycleDly.readNotWrite & ~cycleDly.upperN);
    assign writeLowN  = ~(cycleDly.active & ~cycleDly.readNotWrite & ~cycleDly.lowerN);
    assign readLowN   = ~(cycleDly.active & cycleDly.readNotWrite & ~cycleDly.lowerN);

    assign romN    = sel.rom;
    assign ram0N   = sel.ram0N;
    assign ram1N   = sel.ram1N;
    assign regN    = sel.regs;
    assign ioN     = sel.io;
    assign vramRdN = sel.vramN | readLowN;
    assign vramWrN = sel.vramN | writeLowN; // Video RAMs sit on the low lane
    assign cramWrN = sel.cramN | writeLowN;

    assign intAck   = (cycleDly.fc == FC_INT_ACK);
    assign waitDone = (waitCnt >= WAIT_CNT) && waitQ;

    always_ff @(posedge VRAC2) begin
        if (rst) begin
            state   <= stIdle;
            waitCnt <= '0;
            waitQ   <= 1'b1;
            dtackN  <= 1'b1;
            vpaN    <= 1'b1;
        end else begin
            waitQ <= waitN; // Video hardware wait is asynchronous to the cycle
            case (state)
                stIdle: begin
                    if (sel.valid) begin
                        if (intAck) begin
                            vpaN  <= 1'b0; // Autovector, same timing as fast memory
                            state <= stAcked;
                        end else if (!sel.slow || (WAIT_STATES == 0 && waitQ)) begin
                            dtackN <= 1'b0;
                            state  <= stAcked;
                        end else begin
                            waitCnt <= CNT_W'(1);
                            state   <= stWaiting;
                        end
                    end
                end
                stWaiting: begin
                    if (!cycleDly.active) begin
                        state <= stIdle; // Cycle aborted
                    end else if (waitDone) begin
                        dtackN <= 1'b0;
                        state  <= stAcked;
                    end else if (waitCnt < WAIT_CNT) begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
                stAcked: begin
                    // Hold the answer until the strobe drops
                    if (!cycleDly.active) begin
                        dtackN <= 1'b1;
                        vpaN   <= 1'b1;
                        state  <= stIdle;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

endmodule

// ==== design/videoBusGlue.sv ====
// Top level of the CPU bus glue; connects sampler, map decoder and strobe generator
module videoBusGlue #(
    parameter int WAIT_STATES = 2
) (
    input  logic              VRAC2,
    input  logic              rst,
    input  busPkg::cpuAddr_t  addr,
    input  logic              rdWrN,
    input  logic              asN,
    input  logic              udsN,
    input  logic              ldsN,
    input  busPkg::funcCode_t fc,
    input  logic              soundIntN,
    input  logic              vblankIntN,
    input  logic              int3N,
    input  logic              joystickIntN,
    input  logic              int1N,
    input  logic              waitN,
    output mapPkg::romBank_t  romN,
    output logic              ram0N,
    output logic              ram1N,
    output logic              vramRdN,
    output logic              vramWrN,
    output logic              cramWrN,
    output mapPkg::regSel_t   regN,
    output mapPkg::ioSel_t    ioN,
    output logic              writeHighN,
    output logic              writeLowN,
    output logic              readLowN,
    output logic              dtackN,
    output logic              vpaN,
    output busPkg::intLevel_t iplN
);

    import busPkg::*;
    import mapPkg::*;

    busCycle_t cycle;    // One edge after the pins
    busCycle_t cycleDly; // Aligned with sel
    mapSel_t   sel;

    busSampler sampler (
        .VRAC2        (VRAC2),
        .rst          (rst),
        .addr         (addr),
        .rdWrN        (rdWrN),
        .asN          (asN),
        .udsN         (udsN),
        .ldsN         (ldsN),
        .fc           (fc),
        .soundIntN    (soundIntN),
        .vblankIntN   (vblankIntN),
        .int3N        (int3N),
        .joystickIntN (joystickIntN),
        .int1N        (int1N),
        .cycle        (cycle),
        .iplN         (iplN)
    );

    addressDecoder decoder (
        .VRAC2    (VRAC2),
        .rst      (rst),
        .cycle    (cycle),
        .sel      (sel),
        .cycleDly (cycleDly)
    );

    strobeGen #(
        .WAIT_STATES (WAIT_STATES)
    ) strobes (
        .VRAC2      (VRAC2),
        .rst        (rst),
        .sel        (sel),
        .cycleDly   (cycleDly),
        .waitN      (waitN),
        .romN       (romN),
        .ram0N      (ram0N),
        .ram1N      (ram1N),
        .vramRdN    (vramRdN),
        .vramWrN    (vramWrN),
        .cramWrN    (cramWrN),
        .regN       (regN),
        .ioN        (ioN),
        .writeHighN (writeHighN),
        .writeLowN  (writeLowN),
        .readLowN   (readLowN),
        .dtackN     (dtackN),
        .vpaN       (vpaN)
    );

endmodule

// ==== verification/busGlue_checker.sv ====
// Assertions bound into strobeGen; watch the acknowledge pins and the memory selects
module busGlueChecker (
    input logic             VRAC2,
    input logic             rst,
    input mapPkg::mapSel_t  sel,
    input mapPkg::romBank_t romN,
    input logic             ram0N,
    input logic             ram1N,
    input logic             dtackN,
    input logic             vpaN
);

    int         failCount = 0;
    logic [7:0] memLow; // One bit per memory device, high when selected

    assign memLow = {~romN, ~ram0N, ~ram1N, ~sel.vramN, ~sel.cramN};

    ackExclusive: assert property (@(posedge VRAC2) disable iff (rst) !(!dtackN && !vpaN))
        else begin
            $error("dtackN and vpaN low together");
            failCount++;
        end

    oneMemory: assert property (@(posedge VRAC2) disable iff (rst) $countones(memLow) <= 1)
        else begin
            $error("more than one memory select low");
            failCount++;
        end

    // Acknowledge released by reset
    resetAck: assert property (@(posedge VRAC2) rst |=> dtackN)
        else begin
            $error("dtackN low right after reset");
            failCount++;
        end

endmodule

bind strobeGen busGlueChecker ackRules (
    .VRAC2  (VRAC2),
    .rst    (rst),
    .sel    (sel),
    .romN   (romN),
    .ram0N  (ram0N),
    .ram1N  (ram1N),
    .dtackN (dtackN),
    .vpaN   (vpaN)
);

// ==== verification/videoBusGlueTb.sv ====
// Testbench for videoBusGlue; drives CPU bus accesses and interrupt patterns, checks against the map
module videoBusGlueTb;

    import busPkg::*;
    import mapPkg::*;

    localparam int WAIT_STATES = 2;
    localparam int NUM_ACCESS  = 224; // 200 random, 16 timing, 4 IACK, 4 illegal direction
    localparam int CYCLE_LIMIT = 40 * NUM_ACCESS;

    logic       VRAC2 = 1'b0;
    logic       rst = 1'b1;
    cpuAddr_t   addr;
    funcCode_t  fc;
    logic       rdWrN, asN, udsN, ldsN, waitN;
    logic       soundIntN, vblankIntN, int3N, joystickIntN, int1N;
    romBank_t   romN;
    regSel_t    regN;
    ioSel_t     ioN;
    intLevel_t  iplN;
    logic       ram0N, ram1N, vramRdN, vramWrN, cramWrN;
    logic       writeHighN, writeLowN, readLowN, dtackN, vpaN;

    int         errors = 0;
    int         checks = 0;
    int         cycleCount = 0;
    int         edgeCount = 0;  // Rising edges since asN fell
    logic       accessOn = 1'b0;
    logic       acked = 1'b0;
    logic       waitAt [0:63];  // waitN as seen at each edge of the access
    busCycle_t  cur;            // Access under test as the CPU drives it

    videoBusGlue #(.WAIT_STATES(WAIT_STATES)) DUT (.*);

    always #2 VRAC2 = ~VRAC2;

    function automatic mapSel_t idleSel(input logic valid);
        mapSel_t s;
        s       = '1; // Every select high
        s.slow  = 1'b0;
        s.valid = valid;
        return s;
    endfunction

    // Reference memory map
    function automatic mapSel_t expectSel(input busCycle_t c);
        mapSel_t s;
        s = idleSel(1'b1);
        if (c.fc == 3'b111) begin
            return s; // CPU space, no memory touched
        end
        case (c.addr[23:22])
            2'b00: if (c.readNotWrite) s.rom[c.addr[17:16]] = 1'b0;
            2'b01: begin
                if (c.addr[12]) begin
                    s.ram1N = 1'b0;
                end else begin
                    s.ram0N = 1'b0;
                end
            end
            2'b10: begin
                if (c.addr[21:20] == 2'b00) begin
                    if (!c.readNotWrite && !c.lowerN && c.addr[19:17] != 3'd7)
                        s.regs[c.addr[19:17]] = 1'b0;
                end else if (c.addr[21:20] == 2'b10) begin
                    s.vramN = 1'b0;
                    s.slow  = 1'b1;
                end else if (c.addr[21:20] == 2'b11) begin
                    s.cramN = 1'b0;
                    s.slow  = 1'b1;
                end
            end
            default: begin
                if (c.addr[19:17] < 3'd4) s.io[c.addr[19:17]] = 1'b0; // Spares stay high
                s.slow = 1'b1;
            end
        endcase
        return s;
    endfunction

    // p is sound, vblank, int3, joystick, int1 from the top, all active low
    function automatic intLevel_t expectLevel(input logic [4:0] p);
        if (!p[4]) return 3'd6;
        else if (!p[3]) return 3'd4;
        else if (!p[2]) return 3'd3;
        else if (!p[1]) return 3'd2;
        else if (!p[0]) return 3'd1;
        return 3'd0;
    endfunction

    // Pins where they exist, the rest from the decoder register
    function automatic mapSel_t observedSel();
        mapSel_t s;
        s       = DUT.sel;
        s.rom   = romN;
        s.ram0N = ram0N;
        s.ram1N = ram1N;
        s.regs  = regN;
        s.io    = ioN;
        return s;
    endfunction

    task automatic countFailure(input string msg);
        checks++;
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic checkSel(input string name, input mapSel_t got, input mapSel_t expSel);
        checks++;
        if (got !== expSel) begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, expSel);
        end
    endtask

    task automatic checkIpl(input string name, input intLevel_t got, input intLevel_t expLvl);
        checks++;
        if (got !== expLvl) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, expLvl);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic expBit);
        checks++;
        if (got !== expBit) begin
            errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, expBit);
        end
    endtask

    task automatic compareAccess();
        mapSel_t expSel;
        logic    expRl;
        logic    expWl;
        expSel = expectSel(cur);
        expRl  = ~cur.readNotWrite | cur.lowerN;
        expWl  = cur.readNotWrite | cur.lowerN;
        checkSel("sel", observedSel(), expSel);
        checkBit("writeHighN", writeHighN, cur.readNotWrite | cur.upperN);
        checkBit("writeLowN", writeLowN, expWl);
        checkBit("readLowN", readLowN, expRl);
        checkBit("vramRdN", vramRdN, expSel.vramN | expRl);
        checkBit("vramWrN", vramWrN, expSel.vramN | expWl);
        checkBit("cramWrN", cramWrN, expSel.cramN | expWl);
        checkBit("dtackN", dtackN, cur.fc == 3'b111);
        checkBit("vpaN", vpaN, cur.fc != 3'b111);
        if (!expSel.slow && edgeCount != 3)
            countFailure($sformatf("fast access acknowledged after %0d cycles, not 3",
                                   edgeCount));
        if (expSel.slow && edgeCount < 3 + WAIT_STATES)
            countFailure($sformatf("slow access acknowledged after only %0d cycles", edgeCount));
        if (expSel.slow && edgeCount inside {[1:64]} && !waitAt[6'(edgeCount - 1)])
            countFailure("slow access acknowledged while waitN was held low");
    endtask

    // Watchdog
    always @(posedge VRAC2) begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(posedge VRAC2) begin
        if (accessOn) begin
            edgeCount++;
            if (edgeCount < 64) waitAt[6'(edgeCount)] = waitN;
        end
    end

    // Compare once the acknowledge shows up
    always @(negedge VRAC2) begin
        if (accessOn && !acked && (!dtackN || !vpaN)) begin
            compareAccess();
            acked = 1'b1;
        end
    end

    task automatic runAccess(input cpuAddr_t a, input logic rd, input logic u, input logic l,
                             input funcCode_t f, input int holdWait);
        @(posedge VRAC2);
        #1;
        cur       = '{addr: a, readNotWrite: rd, upperN: u, lowerN: l, fc: f, active: 1'b1};
        addr      = a;
        rdWrN     = rd;
        udsN      = u;
        ldsN      = l;
        fc        = f;
        asN       = 1'b0;
        waitN     = (holdWait == 0);
        edgeCount = 0;
        acked     = 1'b0;
        accessOn  = 1'b1;
        while (!acked) begin
            @(posedge VRAC2);
            #1;
            if (edgeCount >= holdWait) waitN = 1'b1; // Video hardware lets go
        end
        asN      = 1'b1;
        udsN     = 1'b1;
        ldsN     = 1'b1;
        fc       = 3'b101;
        accessOn = 1'b0;
        while (!dtackN || !vpaN) @(negedge VRAC2);
    endtask

    task automatic endTest(input string name, input int base);
        $display("%s: %0d errors", name, errors - base);
    endtask

    initial begin
        int        i;
        int        base;
        int        pick;
        int        failures;
        cpuAddr_t  a;
        logic [4:0] pattern;
        intLevel_t prevLevel;
        void'($urandom(76891));
        addr = '0;
        fc = 3'b101;
        rdWrN = 1'b1;
        asN = 1'b1;
        udsN = 1'b1;
        ldsN = 1'b1;
        waitN = 1'b1;
        {soundIntN, vblankIntN, int3N, joystickIntN, int1N} = 5'b11111;
        cur = '0;
        repeat (4) @(posedge VRAC2);
        #1;
        rst = 1'b0;

        base = errors;
        @(negedge VRAC2);
        checkSel("sel", observedSel(), idleSel(1'b0));
        checkBit("dtackN", dtackN, 1'b1);
        checkBit("vpaN", vpaN, 1'b1);
        checkBit("vramRdN", vramRdN, 1'b1);
        checkBit("vramWrN", vramWrN, 1'b1);
        checkBit("cramWrN", cramWrN, 1'b1);
        checkIpl("iplN", iplN, 3'b111);
        endTest("reset state", base);

        base = errors;
        for (i = 0; i < 200; i++) begin
            pick = $urandom % 3; // Both lanes, lower only, upper only
            a = cpuAddr_t'($urandom) & 24'hFFFFFE;
            runAccess(a, 1'($urandom), pick == 1, pick == 2,
                      ($urandom % 2) ? 3'b101 : 3'b001, int'($urandom % 5));
        end
        endTest("random accesses", base);

        base = errors;
        for (i = 0; i < 8; i++) begin
            a = cpuAddr_t'($urandom) & 24'h7FFFFE; // ROM or work RAM
            runAccess(a, 1'b1, 1'b0, 1'b0, 3'b101, i);
            a = cpuAddr_t'($urandom) & 24'hFFFFFE;
            a[23:21] = i[0] ? 3'b111 : 3'b101; // I/O or VRAM/CRAM
            runAccess(a, 1'b0, 1'b1, 1'b0, 3'b101, i);
        end
        endTest("acknowledge timing", base);

        base = errors;
        for (i = 1; i <= 4; i++) begin
            runAccess({20'hFFFFF, 3'(i), 1'b1}, 1'b1, 1'b1, 1'b0, 3'b111, 0);
        end
        endTest("interrupt acknowledge", base);

        base = errors;
        prevLevel = 3'd0;
        for (i = 0; i < 50; i++) begin
            @(posedge VRAC2);
            #1;
            pattern = 5'($urandom);
            {soundIntN, vblankIntN, int3N, joystickIntN, int1N} = pattern;
            @(negedge VRAC2);
            checkIpl("iplN", iplN, ~prevLevel); // Not yet registered
            @(negedge VRAC2);
            checkIpl("iplN", iplN, ~expectLevel(pattern));
            prevLevel = expectLevel(pattern);
        end
        @(posedge VRAC2);
        #1;
        {soundIntN, vblankIntN, int3N, joystickIntN, int1N} = 5'b11111;
        endTest("interrupt levels", base);

        base = errors;
        runAccess(24'h010000, 1'b0, 1'b0, 1'b0, 3'b101, 0);
        runAccess(24'h020002, 1'b0, 1'b1, 1'b0, 3'b101, 0);
        runAccess(24'h800000, 1'b1, 1'b1, 1'b0, 3'b101, 0);
        runAccess(24'h8A0000, 1'b1, 1'b0, 1'b0, 3'b101, 0);
        endTest("wrong direction", base);

        failures = errors + DUT.strobes.ackRules.failCount;
        $display("checks: %0d, errors: %0d", checks, failures);
        if (failures == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
design/busPkg.sv
design/mapPkg.sv
design/busSampler.sv
design/addressDecoder.sv
design/strobeGen.sv
design/videoBusGlue.sv
verification/busGlue_checker.sv
verification/videoBusGlueTb.sv

// ==== Makefile ====
TOP = videoBusGlueTb

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir -o simv
	./obj_dir/simv +verilator+error+limit+1000 | tee sim.log
	grep -q "^TEST PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
